//--- Makefile
# Verilator build and run of the MSX bus fabric testbench

BIN := obj_dir/Vtb_msx_core

.PHONY: all run clean

all: $(BIN)

$(BIN): all.f $(wildcard source/*.sv source/*.svh testbench/*.sv)
	verilator --binary --timing --assert -f all.f --top-module tb_msx_core -o Vtb_msx_core

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

//--- all.f
+incdir+source
source/msx_bus_pkg.sv
source/msx_audio_pkg.sv
source/cpu_bus_if.sv
source/ppi_slot_select.sv
source/subslot_expander.sv
source/audio_mixer.sv
source/msx_core.sv
testbench/msx_checker.sv
testbench/tb_msx_core.sv

//--- source/audio_mixer.sv
`timescale 1ns/1ps

// PSG, key click, cassette and device sound mixed to one 16-bit sample
module audio_mixer
   import msx_audio_pkg::*;
(
   input  logic           clock_bus,
   input  logic           rst_n,
   input  psg_level_t     psg_level,
   input  logic           key_beep,
   input  logic           cas_motor,
   input  logic           cas_audio_in,
   input  device_sample_t device_sound,
   output audio_sample_t  audio
);

   psg_level_t    psg_sum;
   logic [16:0]   mix;
   mix_range_t    mix_range;
   audio_sample_t mixed;

   // Cassette input is only heard while the motor is stopped
   assign psg_sum = psg_level
                  + {4'b0000, key_beep, 5'b00000}
                  + {5'b00000, cas_audio_in & ~cas_motor, 4'b0000};

   assign mix = {3'b000, psg_sum, 4'b0000} + {device_sound[15], device_sound};

   always_comb begin
      case (mix[16:14])
         3'b000, 3'b111:         mix_range = in_range;
         3'b001, 3'b010, 3'b011: mix_range = clip_high;
         default:                mix_range = clip_low;
      endcase
   end

   // Pass keeps the sign bit and doubles the low 14 bits
   always_comb begin
      case (mix_range)
         in_range:  mixed = {mix[16], mix[13:0], 1'b0};
         clip_high: mixed = 16'h7FFF;
         default:   mixed = 16'h8000;
      endcase
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         audio <= '0;
      end else begin
         audio <= mixed;
      end
   end

endmodule

//--- source/cpu_bus_if.sv
`timescale 1ns/1ps

// Accepted CPU cycle, as seen by the slot logic
interface cpu_bus_if
   import msx_bus_pkg::*;
();

   // High only in the cycle where the request is accepted
   logic      strobe;
   logic      iorq;
   logic      wr;
   cpu_addr_t addr;
   cpu_data_t wdata;

   modport master (
      output strobe,
      output iorq,
      output wr,
      output addr,
      output wdata
   );

   modport slave (
      input strobe,
      input iorq,
      input wr,
      input addr,
      input wdata
   );

endinterface

//--- source/msx_audio_pkg.sv
package msx_audio_pkg;

   // PSG channel mix, unsigned
   typedef logic [9:0]         psg_level_t;

   // Sound from cartridge devices
   typedef logic signed [15:0] device_sample_t;

   // Final mixed sample
   typedef logic [15:0]        audio_sample_t;

   // Compressor cases, from the top three bits of the 17-bit sum
   typedef enum logic [1:0] {
      in_range,
      clip_high,
      clip_low
   } mix_range_t;

endpackage

//--- source/msx_bus_config.svh
`ifndef MSX_BUS_CONFIG_SVH
`define MSX_BUS_CONFIG_SVH

// Build-wide bus configuration of the MSX core

// PPI I/O base A8, ports A8 to AB
// Compared against the upper five bits of the low address byte
`define MSX_PORT_PPI 5'b10101

// Primary slots fitted with a slot expander
// Bit n set means primary slot n is expanded
// Only slot 3 carries an expander here, as on most MSX machines
`define MSX_EXPANDED_SLOTS 4'b1000

// Secondary slot register, seen in page 3 of an expanded slot
// Writes store the subslot map, reads return it inverted
`define MSX_SUBSLOT_ADDR 16'hFFFF

`endif

//--- source/msx_bus_pkg.sv
package msx_bus_pkg;

   // Z80 address and data
   typedef logic [15:0] cpu_addr_t;
   typedef logic [7:0]  cpu_data_t;

   // Primary or secondary slot number
   typedef logic [1:0]  slot_t;

   // 16 KB page, address bits 15:14
   typedef logic [1:0]  page_t;

   // Offset inside a page, address bits 13:0
   typedef logic [13:0] page_offset_t;

   // Source that answers a CPU read
   typedef enum logic [2:0] {
      src_ppi,
      src_subslot,
      src_memory,
      src_kbd,
      src_none
   } read_src_t;

endpackage

//--- source/msx_core.sv
`timescale 1ns/1ps
`include "msx_bus_config.svh"

// CPU-side bus fabric of the MSX core
module msx_core
   import msx_bus_pkg::*;
   import msx_audio_pkg::*;
(
   input  logic           clock_bus,
   input  logic           rst_n,
   input  logic           req_valid,
   output logic           req_ready,
   input  logic           req_iorq,
   input  logic           req_wr,
   input  cpu_addr_t      req_addr,
   input  cpu_data_t      req_wdata,
   output logic           rsp_valid,
   input  logic           rsp_ready,
   output cpu_data_t      rsp_rdata,
   output slot_t          mem_slot,
   output slot_t          mem_subslot,
   output page_t          mem_page,
   output page_offset_t   mem_offset,
   input  cpu_data_t      mem_rdata,
   input  cpu_data_t      kb_data,
   output logic [3:0]     kb_row,
   output logic           cas_motor,
   input  logic           cas_audio_in,
   input  psg_level_t     psg_level,
   input  device_sample_t device_sound,
   output audio_sample_t  audio
);

   logic       accept;
   logic       ppi_sel;
   logic       sub_claim;
   logic       key_beep;
   logic [7:0] page_slots;
   slot_t      active_slot;
   slot_t      active_subslot;
   cpu_data_t  ppi_rdata;
   cpu_data_t  sub_rdata;
   cpu_data_t  read_data;
   read_src_t  read_src;

   cpu_bus_if bus ();

   // One cycle in flight, a pending response blocks new requests
   assign req_ready = ~rsp_valid;
   assign accept    = req_valid & req_ready;

   assign bus.strobe = accept;
   assign bus.iorq   = req_iorq;
   assign bus.wr     = req_wr;
   assign bus.addr   = req_addr;
   assign bus.wdata  = req_wdata;

   // I/O decoder
   assign ppi_sel = req_iorq && (req_addr[7:3] == `MSX_PORT_PPI);

   ppi_slot_select u_ppi (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .bus        (bus),
      .sel        (ppi_sel),
      .kb_data    (kb_data),
      .rdata      (ppi_rdata),
      .active_slot(active_slot),
      .page_slots (page_slots),
      .kb_row     (kb_row),
      .cas_motor  (cas_motor),
      .key_beep   (key_beep)
   );

   subslot_expander u_subslot (
      .clock_bus     (clock_bus),
      .rst_n         (rst_n),
      .bus           (bus),
      .active_slot   (active_slot),
      .page_slots    (page_slots),
      .active_subslot(active_subslot),
      .claim         (sub_claim),
      .rdata         (sub_rdata)
   );

   audio_mixer u_mixer (
      .clock_bus   (clock_bus),
      .rst_n       (rst_n),
      .psg_level   (psg_level),
      .key_beep    (key_beep),
      .cas_motor   (cas_motor),
      .cas_audio_in(cas_audio_in),
      .device_sound(device_sound),
      .audio       (audio)
   );

   // Read source priority, port B goes straight to the keyboard
   always_comb begin
      if (ppi_sel) begin
         read_src = (req_addr[1:0] == 2'd1) ? src_kbd : src_ppi;
      end else if (sub_claim) begin
         read_src = src_subslot;
      end else if (!req_iorq) begin
         read_src = src_memory;
      end else begin
         read_src = src_none;
      end
   end

   always_comb begin
      case (read_src)
         src_ppi:     read_data = ppi_rdata;
         src_kbd:     read_data = kb_data;
         src_subslot: read_data = sub_rdata;
         src_memory:  read_data = mem_rdata;
         default:     read_data = 8'hFF;
      endcase
   end

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else if (accept) begin
         rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
         rsp_valid <= 1'b0;
      end
   end

   // Writes answer with FF
   always_ff @(posedge clock_bus) begin
      if (accept) begin
         rsp_rdata <= req_wr ? 8'hFF : read_data;
      end
   end

   assign mem_slot    = active_slot;
   assign mem_subslot = active_subslot;
   assign mem_page    = req_addr[15:14];
   assign mem_offset  = req_addr[13:0];

   a_rsp_held: assert property (
      @(posedge clock_bus) disable iff (!rst_n)
      (rsp_valid && !rsp_ready) |=> rsp_valid
   );

endmodule

//--- source/ppi_slot_select.sv
`timescale 1ns/1ps

// 8255 subset used by the MSX slot logic and keyboard
module ppi_slot_select
   import msx_bus_pkg::*;
(
   input  logic        clock_bus,
   input  logic        rst_n,
   cpu_bus_if.slave    bus,
   input  logic        sel,
   input  cpu_data_t   kb_data,
   output cpu_data_t   rdata,
   output slot_t       active_slot,
   output logic [7:0]  page_slots,
   output logic [3:0]  kb_row,
   output logic        cas_motor,
   output logic        key_beep
);

   cpu_data_t port_a;
   cpu_data_t port_c;
   logic      map_valid;
   logic      ppi_access;
   page_t     page;

   assign ppi_access = bus.strobe & sel;
   assign page       = bus.addr[15:14];

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         port_a    <= '0;
         port_c    <= '0;
         map_valid <= 1'b0;
      end else if (ppi_access) begin
         // Any access, read or write, makes the slot map valid
         map_valid <= 1'b1;
         if (bus.wr) begin
            case (bus.addr[1:0])
               2'd0: port_a <= bus.wdata;
               2'd2: port_c <= bus.wdata;
               2'd3: begin
                  // Bit set/reset on port C, mode words are ignored
                  if (!bus.wdata[7]) begin
                     port_c[bus.wdata[3:1]] <= bus.wdata[0];
                  end
               end
               // Port B is input only
               default: ;
            endcase
         end
      end
   end

   // Two bits of port A per page
   always_comb begin
      if (!map_valid) begin
         active_slot = 2'b00;
      end else begin
         case (page)
            2'd0:    active_slot = port_a[1:0];
            2'd1:    active_slot = port_a[3:2];
            2'd2:    active_slot = port_a[5:4];
            default: active_slot = port_a[7:6];
         endcase
      end
   end

   always_comb begin
      case (bus.addr[1:0])
         2'd0:    rdata = port_a;
         2'd1:    rdata = kb_data;
         2'd2:    rdata = port_c;
         default: rdata = 8'hFF;
      endcase
   end

   assign page_slots = port_a;
   assign kb_row     = port_c[3:0];
   assign cas_motor  = port_c[4];
   assign key_beep   = port_c[7];

   // Slot 0 until the first PPI access, whatever port A holds
   a_slot_zero_before_map: assert property (
      @(posedge clock_bus) disable iff (!rst_n)
      !map_valid |-> (active_slot == 2'b00)
   );

endmodule

//--- source/subslot_expander.sv
`timescale 1ns/1ps
`include "msx_bus_config.svh"

// Secondary slot registers for the expanded primary slots
module subslot_expander
   import msx_bus_pkg::*;
(
   input  logic       clock_bus,
   input  logic       rst_n,
   cpu_bus_if.slave   bus,
   input  slot_t      active_slot,
   input  logic [7:0] page_slots,
   output slot_t      active_subslot,
   output logic       claim,
   output cpu_data_t  rdata
);

   localparam logic [3:0] expanded_mask = `MSX_EXPANDED_SLOTS;

   cpu_data_t  sub_regs [4];
   slot_t      page3_slot;
   logic       page3_expanded;
   cpu_data_t  active_reg;

   // FFFF always lives in page 3, so its slot comes from port A bits 7:6
   assign page3_slot     = page_slots[7:6];
   assign page3_expanded = expanded_mask[page3_slot];

   assign claim = !bus.iorq && (bus.addr == `MSX_SUBSLOT_ADDR) && page3_expanded;

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 4; i++) begin
            sub_regs[i] <= '0;
         end
      end else if (bus.strobe && claim && bus.wr) begin
         sub_regs[page3_slot] <= bus.wdata;
      end
   end

   // The expander register reads back inverted
   assign rdata = ~sub_regs[page3_slot];

   assign active_reg = sub_regs[active_slot];

   always_comb begin
      if (!expanded_mask[active_slot]) begin
         active_subslot = 2'b00;
      end else begin
         case (bus.addr[15:14])
            2'd0:    active_subslot = active_reg[1:0];
            2'd1:    active_subslot = active_reg[3:2];
            2'd2:    active_subslot = active_reg[5:4];
            default: active_subslot = active_reg[7:6];
         endcase
      end
   end

   // A non-expanded slot in page 3 leaves FFFF to memory
   a_claim_only_expanded: assert property (
      @(posedge clock_bus) disable iff (!rst_n)
      claim |-> expanded_mask[page_slots[7:6]]
   );

endmodule

//--- testbench/msx_checker.sv
`timescale 1ns/1ps

// Watches the DUT ports and compares them with the expected record
module msx_checker
   import msx_bus_pkg::*;
   import msx_audio_pkg::*;
(
   input  logic          clock_bus,
   input  logic          rst_n,
   input  logic          req_valid,
   input  logic          req_ready,
   input  logic          rsp_valid,
   input  logic          rsp_ready,
   input  cpu_data_t     rsp_rdata,
   input  slot_t         mem_slot,
   input  slot_t         mem_subslot,
   input  page_t         mem_page,
   input  page_offset_t  mem_offset,
   input  logic [3:0]    kb_row,
   input  logic          cas_motor,
   input  audio_sample_t audio,
   input  cpu_data_t     exp_rdata,
   input  slot_t         exp_slot,
   input  slot_t         exp_subslot,
   input  page_t         exp_page,
   input  page_offset_t  exp_offset,
   input  logic [3:0]    exp_kb_row,
   input  logic          exp_cas_motor,
   input  audio_sample_t exp_audio,
   input  logic          audio_chk,
   output int            error_count
);

   int        errors = 0;
   logic      held = 1'b0;
   logic      accepted = 1'b0;
   cpu_data_t held_data;

   assign error_count = errors;

   always @(posedge clock_bus) begin
      if (!rst_n) begin
         held     <= 1'b0;
         accepted <= 1'b0;
      end else begin
         // Memory select is checked in the accept cycle
         if (req_valid && req_ready) begin
            if (mem_slot != exp_slot || mem_subslot != exp_subslot || mem_page != exp_page) begin
               $display("Mismatch at %0t: slot/subslot/page %0d/%0d/%0d, expected %0d/%0d/%0d",
                        $time, mem_slot, mem_subslot, mem_page,
                        exp_slot, exp_subslot, exp_page);
               errors = errors + 1;
            end
            if (mem_offset != exp_offset) begin
               $display("Mismatch at %0t: mem_offset %h, expected %h",
                        $time, mem_offset, exp_offset);
               errors = errors + 1;
            end
         end
         // Response is due one cycle after acceptance
         if (accepted && !rsp_valid) begin
            $display("At %0t no response followed the accepted request by one cycle",
                     $time);
            errors = errors + 1;
         end
         accepted <= req_valid && req_ready;
         if (rsp_valid && rsp_ready) begin
            if (rsp_rdata != exp_rdata) begin
               $display("Mismatch at %0t: rsp_rdata %h, expected %h",
                        $time, rsp_rdata, exp_rdata);
               errors = errors + 1;
            end
            if (kb_row != exp_kb_row || cas_motor != exp_cas_motor) begin
               $display("Mismatch at %0t: kb_row %h cas_motor %b, expected %h %b",
                        $time, kb_row, cas_motor, exp_kb_row, exp_cas_motor);
               errors = errors + 1;
            end
         end
         // Only one cycle may be in flight
         if (rsp_valid && req_ready) begin
            $display("At %0t the DUT was ready for a request while a response was pending",
                     $time);
            errors = errors + 1;
         end
         if (held && rsp_valid && rsp_rdata != held_data) begin
            $display("Mismatch at %0t: stalled rsp_rdata changed to %h from %h",
                     $time, rsp_rdata, held_data);
            errors = errors + 1;
         end
         held      <= rsp_valid && !rsp_ready;
         held_data <= rsp_rdata;
         if (audio_chk && audio != exp_audio) begin
            $display("Mismatch at %0t: audio %h, expected %h", $time, audio, exp_audio);
            errors = errors + 1;
         end
      end
   end

endmodule

//--- testbench/msx_golden.txt
# kind(1=audio) iorq wr addr wdata mem_rdata kb_data stall psg dev cas_in
# then expected: rdata slot subslot page kb_row cas_motor audio, all hex
0 0 0 0000 00 11 00 0 000 0000 0 11 0 0 0 0 0 0000
0 0 0 4123 00 22 00 0 000 0000 0 22 0 0 1 0 0 0000
0 0 0 8000 00 33 00 0 000 0000 0 33 0 0 2 0 0 0000
0 0 0 FFFF 00 44 00 0 000 0000 0 44 0 0 3 0 0 0000
0 1 0 0010 00 00 00 0 000 0000 0 FF 0 0 0 0 0 0000
0 1 1 00A8 E4 00 00 0 000 0000 0 FF 0 0 0 0 0 0000
0 0 0 0100 00 55 00 0 000 0000 0 55 0 0 0 0 0 0000
0 0 0 4000 00 56 00 0 000 0000 0 56 1 0 1 0 0 0000
0 0 0 8000 00 57 00 0 000 0000 0 57 2 0 2 0 0 0000
0 0 0 C000 00 58 00 0 000 0000 0 58 3 0 3 0 0 0000
0 1 0 00A8 00 00 00 0 000 0000 0 E4 0 0 0 0 0 0000
0 1 0 00A9 00 00 5A 0 000 0000 0 5A 0 0 0 0 0 0000
0 1 1 00AA 17 00 00 0 000 0000 0 FF 0 0 0 7 1 0000
0 1 1 00AB 08 00 00 0 000 0000 0 FF 0 0 0 7 0 0000
0 1 1 00AB 0F 00 00 0 000 0000 0 FF 0 0 0 7 0 0000
0 1 1 00AB 02 00 00 0 000 0000 0 FF 0 0 0 5 0 0000
0 1 0 00AA 00 00 00 0 000 0000 0 85 0 0 0 5 0 0000
1 0 0 0000 00 00 00 0 000 0000 0 00 0 0 0 0 0 0400
1 0 0 0000 00 00 00 0 010 0000 1 00 0 0 0 0 0 0800
1 0 0 0000 00 00 00 0 100 0123 0 00 0 0 0 0 0 2646
1 0 0 0000 00 00 00 0 300 7000 0 00 0 0 0 0 0 7FFF
1 0 0 0000 00 00 00 0 000 F000 0 00 0 0 0 0 0 E400
1 0 0 0000 00 00 00 0 000 8800 0 00 0 0 0 0 0 8000
0 1 1 00AB 0E 00 00 0 000 0000 0 FF 0 0 0 5 0 0000
1 0 0 0000 00 00 00 0 004 0000 1 00 0 0 0 0 0 0280
0 1 1 00AB 09 00 00 0 000 0000 0 FF 0 0 0 5 1 0000
1 0 0 0000 00 00 00 0 004 0000 1 00 0 0 0 0 0 0080
0 0 1 FFFF 1B 00 00 0 000 0000 0 FF 3 0 3 5 1 0000
0 0 0 FFFF 00 77 00 0 000 0000 0 E4 3 0 3 5 1 0000
0 1 1 00A8 E7 00 00 0 000 0000 0 FF 0 0 0 5 1 0000
0 0 0 0200 00 66 00 0 000 0000 0 66 3 3 0 5 1 0000
0 0 0 4000 00 67 00 0 000 0000 0 67 1 0 1 5 1 0000
0 1 1 00A8 27 00 00 0 000 0000 0 FF 3 3 0 5 1 0000
0 0 0 FFFF 00 88 00 0 000 0000 0 88 0 0 3 5 1 0000
0 0 0 0300 00 99 00 5 000 0000 0 99 3 3 0 5 1 0000
0 1 1 00AA 03 00 00 3 000 0000 0 FF 3 3 0 3 0 0000
0 1 0 00AA 00 00 00 2 000 0000 0 03 3 3 0 3 0 0000

//--- testbench/tb_msx_core.sv
`timescale 1ns/1ps

module tb_msx_core
   import msx_bus_pkg::*;
   import msx_audio_pkg::*;
();

   typedef struct packed {
      logic           audio_line;
      logic           iorq;
      logic           wr;
      cpu_addr_t      addr;
      cpu_data_t      wdata;
      cpu_data_t      mem_data;
      cpu_data_t      kbd;
      logic [3:0]     stall;
      psg_level_t     psg;
      device_sample_t dev;
      logic           cas_in;
      cpu_data_t      rdata;
      slot_t          slot;
      slot_t          subslot;
      page_t          page;
      logic [3:0]     kb_row;
      logic           cas_motor;
      audio_sample_t  audio;
   } golden_t;

   logic clock_bus;
   logic rst_n;
   logic req_valid, req_ready, req_iorq, req_wr;
   cpu_addr_t req_addr;
   cpu_data_t req_wdata, rsp_rdata, mem_rdata, kb_data;
   logic rsp_valid, rsp_ready;
   slot_t mem_slot, mem_subslot;
   page_t mem_page;
   page_offset_t mem_offset;
   logic [3:0] kb_row;
   logic cas_motor, cas_audio_in;
   psg_level_t psg_level;
   device_sample_t device_sound;
   audio_sample_t audio;

   // Expected record handed to the checker
   cpu_data_t exp_rdata;
   slot_t exp_slot, exp_subslot;
   page_t exp_page;
   page_offset_t exp_offset;
   logic [3:0] exp_kb_row;
   logic exp_cas_motor, audio_chk;
   audio_sample_t exp_audio;

   golden_t vectors [64];
   int line_count = 0;
   int protocol_errors = 0;
   int check_errors;
   int cycle_count = 0;
   int cycle_limit = 64 * 20 + 16;

   msx_core u_dut (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready), .req_iorq(req_iorq),
      .req_wr(req_wr), .req_addr(req_addr), .req_wdata(req_wdata),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
      .mem_slot(mem_slot), .mem_subslot(mem_subslot), .mem_page(mem_page),
      .mem_offset(mem_offset), .mem_rdata(mem_rdata), .kb_data(kb_data),
      .kb_row(kb_row), .cas_motor(cas_motor), .cas_audio_in(cas_audio_in),
      .psg_level(psg_level), .device_sound(device_sound), .audio(audio)
   );

   msx_checker u_checker (
      .clock_bus(clock_bus), .rst_n(rst_n),
      .req_valid(req_valid), .req_ready(req_ready),
      .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata),
      .mem_slot(mem_slot), .mem_subslot(mem_subslot), .mem_page(mem_page),
      .mem_offset(mem_offset),
      .kb_row(kb_row), .cas_motor(cas_motor), .audio(audio),
      .exp_rdata(exp_rdata), .exp_slot(exp_slot), .exp_subslot(exp_subslot),
      .exp_page(exp_page), .exp_offset(exp_offset),
      .exp_kb_row(exp_kb_row), .exp_cas_motor(exp_cas_motor),
      .exp_audio(exp_audio), .audio_chk(audio_chk), .error_count(check_errors)
   );

   initial clock_bus = 1'b0;
   always #2 clock_bus = ~clock_bus;

   always @(posedge clock_bus) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         $display("Timeout after %0d cycles, the test did not finish", cycle_count);
         $display("Simulation FAILED");
         $finish;
      end
   end

   task automatic drive_common(input golden_t v);
      psg_level     <= v.psg;
      device_sound  <= v.dev;
      cas_audio_in  <= v.cas_in;
      exp_rdata     <= v.rdata;
      exp_slot      <= v.slot;
      exp_subslot   <= v.subslot;
      exp_page      <= v.page;
      // Offset inside the page is the low 14 address bits
      exp_offset    <= v.addr[13:0];
      exp_kb_row    <= v.kb_row;
      exp_cas_motor <= v.cas_motor;
      exp_audio     <= v.audio;
   endtask

   task automatic run_bus_cycle(input golden_t v, input int line_no);
      int waited;
      @(posedge clock_bus);
      drive_common(v);
      req_valid <= 1'b1;
      req_iorq  <= v.iorq;
      req_wr    <= v.wr;
      req_addr  <= v.addr;
      req_wdata <= v.wdata;
      mem_rdata <= v.mem_data;
      kb_data   <= v.kbd;
      rsp_ready <= (v.stall == 4'd0);
      waited = 0;
      do begin
         @(posedge clock_bus);
         waited++;
      end while (!req_ready && waited < 40);
      req_valid <= 1'b0;
      // Read sources move on after acceptance, a late capture would show
      mem_rdata <= ~v.mem_data;
      kb_data   <= ~v.kbd;
      if (!req_ready) begin
         $display("Request of golden line %0d was never accepted", line_no);
         protocol_errors++;
      end else begin
         // Hold off the response for the stall count
         repeat (v.stall) @(posedge clock_bus);
         rsp_ready <= 1'b1;
         waited = 0;
         do begin
            @(posedge clock_bus);
            waited++;
         end while (!(rsp_valid && rsp_ready) && waited < 40);
         if (!(rsp_valid && rsp_ready)) begin
            $display("No response arrived for golden line %0d", line_no);
            protocol_errors++;
         end
      end
   endtask

   // Mixer output is registered, so it is checked two edges after driving
   task automatic run_audio_sample(input golden_t v);
      @(posedge clock_bus);
      drive_common(v);
      @(posedge clock_bus);
      audio_chk <= 1'b1;
      @(posedge clock_bus);
      audio_chk <= 1'b0;
   endtask

   initial begin
      int fd;
      int code;
      string line;
      logic [15:0] k, io, w, ad, wd, md, kd, st, ps, dv, ci, er, es, eb, ep, ek, ec, ea;
      rst_n = 1'b0;
      req_valid = 1'b0;
      req_iorq = 1'b0;
      req_wr = 1'b0;
      req_addr = '0;
      req_wdata = '0;
      rsp_ready = 1'b1;
      mem_rdata = '0;
      kb_data = '0;
      cas_audio_in = 1'b0;
      psg_level = '0;
      device_sound = '0;
      exp_rdata = '0;
      exp_slot = '0;
      exp_subslot = '0;
      exp_page = '0;
      exp_offset = '0;
      exp_kb_row = '0;
      exp_cas_motor = 1'b0;
      exp_audio = '0;
      audio_chk = 1'b0;
      fd = $fopen("testbench/msx_golden.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the golden file testbench/msx_golden.txt");
         $display("Simulation FAILED");
         $finish;
      end else begin
         while (!$feof(fd) && line_count < 64) begin
            line = "";
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
               code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                              k, io, w, ad, wd, md, kd, st, ps, dv, ci,
                              er, es, eb, ep, ek, ec, ea);
               if (code == 18) begin
                  vectors[line_count].audio_line = k[0];
                  vectors[line_count].iorq       = io[0];
                  vectors[line_count].wr         = w[0];
                  vectors[line_count].addr       = ad;
                  vectors[line_count].wdata      = wd[7:0];
                  vectors[line_count].mem_data   = md[7:0];
                  vectors[line_count].kbd        = kd[7:0];
                  vectors[line_count].stall      = st[3:0];
                  vectors[line_count].psg        = ps[9:0];
                  vectors[line_count].dev        = dv;
                  vectors[line_count].cas_in     = ci[0];
                  vectors[line_count].rdata      = er[7:0];
                  vectors[line_count].slot       = es[1:0];
                  vectors[line_count].subslot    = eb[1:0];
                  vectors[line_count].page       = ep[1:0];
                  vectors[line_count].kb_row     = ek[3:0];
                  vectors[line_count].cas_motor  = ec[0];
                  vectors[line_count].audio      = ea;
                  line_count++;
               end
            end
         end
         $fclose(fd);
         if (line_count == 0) begin
            $display("The golden file holds no usable lines");
            protocol_errors++;
         end
         cycle_limit = line_count * 20 + 16;
         repeat (16) @(posedge clock_bus);
         rst_n <= 1'b1;
         for (int i = 0; i < line_count; i++) begin
            if (vectors[i].audio_line) begin
               run_audio_sample(vectors[i]);
            end else begin
               run_bus_cycle(vectors[i], i);
            end
         end
         repeat (3) @(posedge clock_bus);
         $display("Errors: %0d compare, %0d protocol", check_errors, protocol_errors);
         if (check_errors == 0 && protocol_errors == 0) begin
            $display("Simulation PASSED");
         end else begin
            $display("Simulation FAILED");
         end
         $finish;
      end
   end

endmodule
